// File: filelist.f
+incdir+design
design/routerPkg.sv
design/flitTimer.sv
design/inputPort.sv
design/outputArbiter.sv
design/flitMux.sv
design/routerOutputChannel.sv
sim/tbClock.sv
sim/routerOutputChannel_chk.sv
sim/routerTb.sv

// File: Bender.yml
package:
  name: router_output_channel

sources:
  - include_dirs:
      - design
    files:
      - design/routerPkg.sv
      - design/flitTimer.sv
      - design/inputPort.sv
      - design/outputArbiter.sv
      - design/flitMux.sv
      - design/routerOutputChannel.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/tbClock.sv
      - sim/routerOutputChannel_chk.sv
      - sim/routerTb.sv

// File: sim/routerTb.sv
`timescale 1ns/1ps
`include "router_defs.svh"

module routerTb;

  localparam int ports     = `ROUTER_PORTS;
  localparam int waitLimit = 500;

  typedef struct packed
  {
    logic            joinNext;
    routerPkg::portT port;
    routerPkg::flitT flit;
  } rowT;

  logic                     clk;
  logic                     rst;
  routerPkg::flitT          inFlit [ports];
  logic [ports-1:0]         inStrobe;
  routerPkg::outFlitT       outFlit;

  rowT                      rows [$];
  routerPkg::flitT          expQ [ports][$];
  int                       occupancy [ports];
  logic [`ROUTER_LEN_W-1:0] lastLen [ports];
  logic [ports-1:0]         strobeSeen;
  logic                     rstSeen;
  logic [ports-1:0]         reqOneBack;
  logic [ports-1:0]         reqTwoBack;
  logic                     lastValid;
  routerPkg::portT          lastPort;
  logic                     soloMode;
  routerPkg::portT          soloPort;
  int                       headerStart;
  int                       burstStart;

  tbClock clockGen
  (
    .clk (clk),
    .rst (rst)
  );

  routerOutputChannel dut0
  (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inStrobe (inStrobe),
    .outFlit  (outFlit)
  );

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic checkPort(input string name, input routerPkg::portT actual,
                           input routerPkg::portT expected);
    if (actual !== expected)
      failRun($sformatf("** Error: %s expected 0x%0h got 0x%0h", name, expected, actual));
  endtask

  task automatic checkFlit(input string name, input routerPkg::flitT actual,
                           input routerPkg::flitT expected);
    if (actual !== expected)
      failRun($sformatf("** Error: %s expected 0x%0h got 0x%0h", name, expected, actual));
  endtask

  task automatic checkValid(input string name, input logic actual, input logic expected);
    if (actual !== expected)
      failRun($sformatf("** Error: %s expected 0x%0h got 0x%0h", name, expected, actual));
  endtask

  task automatic addRow(input logic joinNext, input routerPkg::portT port,
                        input routerPkg::flitIdT id, input logic [`ROUTER_PAYLOAD_W-1:0] payload);
    rowT row;
    row.joinNext     = joinNext;
    row.port         = port;
    row.flit.flitId  = id;
    row.flit.payload = payload;
    rows.push_back(row);
  endtask

  // payload high nibble is the port, a header keeps its length in the low bits.
  task automatic buildTable();
    addRow(1'b0, routerPkg::portNorth, routerPkg::flitHeader, 16'h1003);
    addRow(1'b0, routerPkg::portNorth, routerPkg::flitBody,   16'h1101);
    addRow(1'b0, routerPkg::portNorth, routerPkg::flitBody,   16'h1102);
    addRow(1'b0, routerPkg::portNorth, routerPkg::flitTail,   16'h1103);
    headerStart = rows.size();
    addRow(1'b1, routerPkg::portLocal, routerPkg::flitHeader, 16'h0004);
    addRow(1'b1, routerPkg::portNorth, routerPkg::flitHeader, 16'h1002);
    addRow(1'b1, routerPkg::portEast,  routerPkg::flitHeader, 16'h2000);
    addRow(1'b1, routerPkg::portWest,  routerPkg::flitHeader, 16'h3001);
    addRow(1'b0, routerPkg::portSouth, routerPkg::flitHeader, 16'h4003);
    burstStart = rows.size();
    addRow(1'b1, routerPkg::portLocal, routerPkg::flitBody,   16'h0101);
    addRow(1'b1, routerPkg::portNorth, routerPkg::flitBody,   16'h1201);
    addRow(1'b1, routerPkg::portEast,  routerPkg::flitBody,   16'h2101);
    addRow(1'b1, routerPkg::portWest,  routerPkg::flitBody,   16'h3101);
    addRow(1'b0, routerPkg::portSouth, routerPkg::flitBody,   16'h4101);
    addRow(1'b1, routerPkg::portLocal, routerPkg::flitBody,   16'h0102);
    addRow(1'b1, routerPkg::portEast,  routerPkg::flitBody,   16'h2102);
    addRow(1'b0, routerPkg::portSouth, routerPkg::flitBody,   16'h4102);
    addRow(1'b1, routerPkg::portLocal, routerPkg::flitBody,   16'h0103);
    addRow(1'b1, routerPkg::portNorth, routerPkg::flitTail,   16'h1202);
    addRow(1'b1, routerPkg::portEast,  routerPkg::flitBody,   16'h2103);
    addRow(1'b0, routerPkg::portWest,  routerPkg::flitTail,   16'h3102);
    addRow(1'b1, routerPkg::portLocal, routerPkg::flitTail,   16'h0104);
    addRow(1'b1, routerPkg::portEast,  routerPkg::flitBody,   16'h2104);
    addRow(1'b0, routerPkg::portSouth, routerPkg::flitBody,   16'h4103);
    addRow(1'b1, routerPkg::portEast,  routerPkg::flitTail,   16'h2105);
    addRow(1'b0, routerPkg::portSouth, routerPkg::flitTail,   16'h4104);
  endtask

  // rows joined by joinNext share one strobe cycle.
  task automatic applyRows(input int first, input int last, input int maxGap);
    int   i;
    int   p;
    logic more;
    i = first;
    @(negedge clk);
    while (i <= last)
    begin
      more = 1'b1;
      while (more)
      begin
        p = int'(rows[i].port);
        inFlit[p]   = rows[i].flit;
        inStrobe[p] = 1'b1;
        expQ[p].push_back(rows[i].flit);
        more = rows[i].joinNext;
        i++;
      end
      @(negedge clk);
      inStrobe = '0;
      repeat ($urandom_range(maxGap, 0)) @(negedge clk);
    end
  endtask

  task automatic waitDrain(input string what);
    int   c;
    int   n;
    logic busy;
    busy = 1'b1;
    for (c = 0; c < waitLimit && busy; c++)
    begin
      @(posedge clk);
      busy = 1'b0;
      for (n = 0; n < ports; n++)
        if (expQ[n].size() != 0)
          busy = 1'b1;
    end
    if (busy)
      failRun($sformatf("timeout: %s did not drain within %0d cycles", what, waitLimit));
  endtask

  always @(dut0.chk0.failCount)
  begin
    if (dut0.chk0.failCount != 0)
      failRun("a bound assertion on grant or output behavior failed");
  end

  always @(posedge clk)
  begin
    strobeSeen <= inStrobe;
    rstSeen    <= rst;
  end

  // scoreboard for the edge just before this falling edge.
  always @(negedge clk)
  begin
    int p;
    int k;
    routerPkg::flitT want;
    if (rstSeen)
    begin
      reqOneBack = '0;
      reqTwoBack = '0;
      lastValid  = 1'b0;
      for (k = 0; k < ports; k++)
      begin
        occupancy[k] = 0;
        lastLen[k]   = '1;
      end
    end
    else
    begin
      // modeled req levels seen by the arbiter at the previous and the current edge.
      reqTwoBack = reqOneBack;
      for (k = 0; k < ports; k++)
        reqOneBack[k] = (occupancy[k] != 0);
      if (outFlit.valid)
      begin
        p = int'(outFlit.srcPort);
        if (p >= ports)
          failRun("output flit carries an unknown source port");
        if (soloMode)
          checkPort("outFlit.srcPort", outFlit.srcPort, soloPort);
        if (!reqOneBack[p])
          failRun("output flit came from a port whose FIFO was empty");
        if (expQ[p].size() == 0)
          failRun("output flit arrived with nothing expected on its port");
        want = expQ[p].pop_front();
        checkFlit("outFlit.flit", outFlit.flit, want);
        if (lastValid && lastPort == outFlit.srcPort && lastLen[p] == 0 &&
            (reqTwoBack & ~(ports'(1) << p)) != '0)
          failRun("a zero-length port kept the grant while another port requested");
        if (lastValid && lastPort != outFlit.srcPort)
        begin
          if (!reqTwoBack[p])
            failRun("grant moved to a port that was not requesting");
          for (k = (int'(lastPort) + 1) % ports; k != p; k = (k + 1) % ports)
            if (reqTwoBack[k])
              failRun("grant skipped a requesting port in cyclic order");
        end
        if (outFlit.flit.flitId == routerPkg::flitHeader)
          lastLen[p] = outFlit.flit.payload[`ROUTER_LEN_W-1:0];
        occupancy[p]--;
      end
      lastValid = outFlit.valid;
      lastPort  = outFlit.srcPort;
      for (k = 0; k < ports; k++)
        occupancy[k] += strobeSeen[k];
    end
  end

  initial
  begin
    int   c;
    logic seen;
    void'($urandom(32'h1901));
    soloMode   = 1'b0;
    soloPort   = routerPkg::portNorth;
    inStrobe   = '0;
    for (c = 0; c < ports; c++)
      inFlit[c] = '0;
    buildTable();

    seen = 1'b0;
    for (c = 0; c < waitLimit && !seen; c++)
    begin
      @(posedge clk);
      seen = !rst;
    end
    if (!seen)
      failRun("timeout: reset was never released");

    repeat (10)
    begin
      @(negedge clk);
      checkValid("outFlit.valid", outFlit.valid, 1'b0);
    end

    soloMode = 1'b1;
    applyRows(0, headerStart - 1, 2);
    waitDrain("the single north packet");
    repeat (4) @(negedge clk);
    soloMode = 1'b0;

    // all five headers in one cycle while the arbiter sits in idle.
    applyRows(headerStart, burstStart - 1, 0);
    seen = 1'b0;
    for (c = 0; c < waitLimit && !seen; c++)
    begin
      @(negedge clk);
      seen = outFlit.valid;
    end
    if (!seen)
      failRun("timeout: no output flit after loading all five ports");
    checkPort("outFlit.srcPort", outFlit.srcPort, routerPkg::portLocal);

    applyRows(burstStart, rows.size() - 1, 2);
    waitDrain("the contended burst");
    repeat (8) @(negedge clk);

    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: sim/routerOutputChannel_chk.sv
`timescale 1ns/1ps
`include "router_defs.svh"

module routerOutputChannel_chk
(
  input logic                     clk,
  input logic                     rst,
  input logic [`ROUTER_PORTS-1:0] req,
  input logic [`ROUTER_PORTS-1:0] timesup,
  input routerPkg::grantStateT    grant,
  input routerPkg::outFlitT       outFlit
);

  logic [`ROUTER_PORTS-1:0] reqLast;
  int                       failCount = 0;

  always_ff @(posedge clk)
    reqLast <= req;

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(grant))
  else
  begin
    failCount++;
    $error("grant is not one-hot");
  end

  validAfterReset: assert property (@(posedge clk) $fell(rst) |-> !outFlit.valid)
  else
  begin
    failCount++;
    $error("output valid in the cycle after reset");
  end

  // the registered flit left a FIFO that was non-empty one edge earlier.
  validFromRequester: assert property (@(posedge clk) disable iff (rst)
    outFlit.valid |-> reqLast[outFlit.srcPort])
  else
  begin
    failCount++;
    $error("output flit tagged with a port that was not requesting");
  end

  grantHeld: assert property (@(posedge clk) disable iff (rst)
    (grant[`ROUTER_PORTS:1] & req & ~timesup) != '0 |=> $stable(grant))
  else
  begin
    failCount++;
    $error("grant left a port that still requested within its quantum");
  end

endmodule

bind routerOutputChannel routerOutputChannel_chk chk0
(
  .clk     (clk),
  .rst     (rst),
  .req     (req),
  .timesup (outArbiter.timesup),
  .grant   (grant),
  .outFlit (outFlit)
);

// File: sim/tbClock.sv
`timescale 1ns/1ps

module tbClock
(
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever
      #2 clk = ~clk;
  end

  // reset covers the first four rising edges and drops on a falling edge.
  initial
  begin
    rst = 1'b1;
    repeat (4) @(negedge clk);
    rst = 1'b0;
  end

endmodule

// File: design/routerOutputChannel.sv
`timescale 1ns/1ps
`include "router_defs.svh"

module routerOutputChannel
(
  input  logic                     clk,
  input  logic                     rst,
  input  routerPkg::flitT          inFlit [`ROUTER_PORTS],
  input  logic [`ROUTER_PORTS-1:0] inStrobe,
  output routerPkg::outFlitT       outFlit
);

  routerPkg::flitT          headFlit [`ROUTER_PORTS];
  logic [`ROUTER_PORTS-1:0] req;
  routerPkg::grantStateT    grant;

  genvar p;
  generate
    for (p = 0; p < `ROUTER_PORTS; p++)
    begin : portGen
      // each port pops on its own grant bit.
      inputPort inPort
      (
        .clk      (clk),
        .rst      (rst),
        .inFlit   (inFlit[p]),
        .strobe   (inStrobe[p]),
        .pop      (grant[p+1]),
        .headFlit (headFlit[p]),
        .req      (req[p])
      );
    end
  endgenerate

  outputArbiter outArbiter
  (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .headFlit (headFlit),
    .grant    (grant)
  );

  flitMux outMux
  (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .req      (req),
    .headFlit (headFlit),
    .outFlit  (outFlit)
  );

endmodule

// File: design/flitMux.sv
`timescale 1ns/1ps
`include "router_defs.svh"

module flitMux
(
  input  logic                     clk,
  input  logic                     rst,
  input  routerPkg::grantStateT    grant,
  input  logic [`ROUTER_PORTS-1:0] req,
  input  routerPkg::flitT          headFlit [`ROUTER_PORTS],
  output routerPkg::outFlitT       outFlit
);

  logic            selValid;
  routerPkg::portT selPort;
  routerPkg::flitT selFlit;

  // grant bit i+1 belongs to port i, and an idle grant leaves valid low.
  always_comb
  begin
    selValid = 1'b0;
    selPort  = routerPkg::portLocal;
    selFlit  = '0;
    for (int i = 0; i < `ROUTER_PORTS; i++)
    begin
      if (grant[i+1])
      begin
        selValid = req[i];
        selPort  = routerPkg::portT'(i);
        selFlit  = headFlit[i];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    outFlit.srcPort <= selPort;
    outFlit.flit    <= selFlit;
    if (rst)
      outFlit.valid <= 1'b0;
    else
      outFlit.valid <= selValid;
  end

endmodule

// File: design/outputArbiter.sv
`timescale 1ns/1ps
`include "router_defs.svh"

module outputArbiter
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`ROUTER_PORTS-1:0]  req,
  input  routerPkg::flitT           headFlit [`ROUTER_PORTS],
  output routerPkg::grantStateT     grant
);

  localparam int ports = `ROUTER_PORTS;

  routerPkg::grantStateT nextState;
  logic [ports-1:0]      runTimer;
  logic [ports-1:0]      timesup;

  genvar g;
  generate
    for (g = 0; g < ports; g++)
    begin : timerGen
      flitTimer portTimer
      (
        .clk     (clk),
        .rst     (rst),
        .flitId  (headFlit[g].flitId),
        .length  (headFlit[g].payload[`ROUTER_LEN_W-1:0]),
        .run     (runTimer[g]),
        .timesup (timesup[g])
      );
    end
  endgenerate

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= routerPkg::grantIdle;
    else
      grant <= nextState;
  end

  always_comb
  begin
    int   owner;
    int   searchLen;
    int   cand;
    logic holding;
    logic legal;
    logic found;

    owner     = 0;
    searchLen = ports - 1;
    cand      = 0;
    holding   = 1'b1;
    legal     = 1'b1;
    found     = 1'b0;
    runTimer  = '0;
    nextState = routerPkg::grantIdle;

    // from idle the search starts just after south, so local comes first.
    case (grant)
      routerPkg::grantIdle:
      begin
        owner     = ports - 1;
        searchLen = ports;
        holding   = 1'b0;
      end
      routerPkg::grantLocal:
        owner = 0;
      routerPkg::grantNorth:
        owner = 1;
      routerPkg::grantEast:
        owner = 2;
      routerPkg::grantWest:
        owner = 3;
      routerPkg::grantSouth:
        owner = 4;
      default:
        legal = 1'b0;
    endcase

    if (legal)
    begin
      if (holding && req[owner] && !timesup[owner])
      begin
        runTimer[owner] = 1'b1;
        nextState       = grant;
      end
      else
      begin
        // the owner itself is not a candidate, so a lone expired port drops to idle.
        for (int i = 1; i <= ports; i++)
        begin
          cand = owner + i;
          if (cand >= ports)
            cand = cand - ports;
          if (!found && i <= searchLen && req[cand])
          begin
            found     = 1'b1;
            nextState = routerPkg::grantStateT'(6'b1 << (cand + 1));
          end
        end
      end
    end
  end

endmodule

// File: design/inputPort.sv
`timescale 1ns/1ps
`include "router_defs.svh"

module inputPort
(
  input  logic            clk,
  input  logic            rst,
  input  routerPkg::flitT inFlit,
  input  logic            strobe,
  input  logic            pop,
  output routerPkg::flitT headFlit,
  output logic            req
);

  localparam int depth = `ROUTER_FIFO_DEPTH;
  localparam int ptrW  = $clog2(depth);
  localparam int cntW  = $clog2(depth + 1);

  routerPkg::flitT mem [depth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] count;
  logic            full;
  logic            empty;
  logic            push;
  logic            take;

  assign full  = (count == cntW'(depth));
  assign empty = (count == '0);

  // a strobe into a full FIFO is lost, a pop from an empty one does nothing.
  assign push = strobe && !full;
  assign take = pop && !empty;

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
      if (take)
        rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
      case ({push, take})
        2'b10:
          count <= count + 1'b1;
        2'b01:
          count <= count - 1'b1;
        default:
          count <= count;
      endcase
    end
  end

  assign headFlit = mem[rdPtr];
  assign req      = !empty;

endmodule

// File: design/flitTimer.sv
`timescale 1ns/1ps
`include "router_defs.svh"

module flitTimer
(
  input  logic                     clk,
  input  logic                     rst,
  input  routerPkg::flitIdT        flitId,
  input  logic [`ROUTER_LEN_W-1:0] length,
  input  logic                     run,
  output logic                     timesup
);

  logic [`ROUTER_LEN_W-1:0] quantum;
  logic [`ROUTER_LEN_W-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      quantum <= '0;
      count   <= '0;
    end
    else
    begin
      // the quantum follows whichever header currently sits at the port head.
      if (flitId == routerPkg::flitHeader)
        quantum <= length;
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  // a zero length expires in the first granted cycle.
  assign timesup = (count == quantum);

endmodule

// File: design/routerPkg.sv
`include "router_defs.svh"

package routerPkg;

  // flit identifier codes, header is the complement of 3'b001.
  typedef enum logic [2:0]
  {
    flitIdle   = 3'd0,
    flitBody   = 3'd2,
    flitTail   = 3'd3,
    flitHeader = 3'd6
  } flitIdT;

  typedef enum logic [2:0]
  {
    portLocal = 3'd0,
    portNorth = 3'd1,
    portEast  = 3'd2,
    portWest  = 3'd3,
    portSouth = 3'd4
  } portT;

  // one-hot arbiter state, bit 0 is idle and bits 1 to 5 follow the port order.
  typedef enum logic [5:0]
  {
    grantIdle  = 6'b000001,
    grantLocal = 6'b000010,
    grantNorth = 6'b000100,
    grantEast  = 6'b001000,
    grantWest  = 6'b010000,
    grantSouth = 6'b100000
  } grantStateT;

  typedef struct packed
  {
    flitIdT                       flitId;
    logic [`ROUTER_PAYLOAD_W-1:0] payload;
  } flitT;

  typedef struct packed
  {
    logic valid;
    portT srcPort;
    flitT flit;
  } outFlitT;

endpackage

// File: design/router_defs.svh
`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

// flits held by each input FIFO.
`define ROUTER_FIFO_DEPTH 8

// payload bits carried by every flit.
`define ROUTER_PAYLOAD_W 16

// a header flit carries the packet length in the low payload bits.
`define ROUTER_LEN_W 12

// local, north, east, west and south.
`define ROUTER_PORTS 5

`endif
